//--- bench/rv_exu_assert.sv
// rv64i execute front assertions
module rv_exu_assert (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_valid,
  input logic o_valid,
  input logic o_reg_wr, o_mem_rd, o_mem_wr,
  input logic o_br_taken, o_ebreak, o_illegal
);
  timeunit 1ns;
  timeprecision 1ps;

  a_reset_valid: assert property (@(posedge i_clk) !i_rst_n |=> !o_valid)
    else $error("o_valid high in reset or just after it");

  a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $past(i_rst_n, 3) |-> (o_valid == $past(i_valid, 3)))
    else $error("o_valid does not follow i_valid by 3 cycles");

  a_flags_qualified: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_valid |-> !(o_reg_wr || o_mem_rd || o_mem_wr || o_br_taken || o_ebreak || o_illegal))
    else $error("control flag high without o_valid");

endmodule

bind rv_exu_pipe rv_exu_assert assert_i (.*);

//--- bench/rv_exu_model.svh
// rv64i execute reference model
`ifndef RV_EXU_MODEL_SVH
`define RV_EXU_MODEL_SVH

typedef struct {
  logic [63:0] pc, result, wdata, target;
  logic [4:0]  rd;
  logic [2:0]  mem_op;
  logic        reg_wr, mem_rd, mem_wr, taken, ebreak, illegal;
} exp_t;

function automatic logic [63:0] sext_word(input logic [63:0] v);
  return {{32{v[31]}}, v[31:0]};
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [63:0] a, b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

function automatic logic [2:0] mem_code(input logic [2:0] f3);
  case (f3)
    3'b000:  return rv_exu_pkg::MEM_SB;
    3'b001:  return rv_exu_pkg::MEM_SH;
    3'b010:  return rv_exu_pkg::MEM_SW;
    3'b011:  return rv_exu_pkg::MEM_SD;
    3'b100:  return rv_exu_pkg::MEM_UB;
    3'b101:  return rv_exu_pkg::MEM_UH;
    default: return rv_exu_pkg::MEM_NONE;
  endcase
endfunction

function automatic exp_t model_exec(input logic [63:0] pc, input logic [31:0] inst,
                                    input logic [63:0] a, b);
  exp_t        e;
  logic        ok;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] ii, is, ib, iu, ij;
  f3 = inst[14:12];
  f7 = inst[31:25];
  ii = {{52{inst[31]}}, inst[31:20]};
  is = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  ib = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  iu = {{32{inst[31]}}, inst[31:12], 12'b0};
  ij = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  e = '{default: '0};
  e.pc = pc;
  e.rd = inst[11:7];
  e.mem_op = rv_exu_pkg::MEM_NONE;
  ok = 1'b0;
  case (inst[6:0])
    rv_exu_pkg::OP_LUI: begin
      ok = 1'b1;
      e.reg_wr = 1'b1;
      e.result = iu;
    end
    rv_exu_pkg::OP_AUIPC: begin
      ok = 1'b1;
      e.reg_wr = 1'b1;
      e.result = pc + iu;
    end
    rv_exu_pkg::OP_JAL: begin
      ok = 1'b1;
      e.reg_wr = 1'b1;
      e.result = pc + 64'd4;  // link address
      e.taken = 1'b1;
      e.target = pc + ij;
    end
    rv_exu_pkg::OP_JALR: begin
      ok = (f3 == 3'b000);
      e.reg_wr = ok;
      e.result = pc + 64'd4;
      e.taken = ok;
      e.target = (a + ii) & ~64'd1;
    end
    rv_exu_pkg::OP_BRANCH: begin
      ok = (f3[2:1] != 2'b01);
      e.taken = ok & branch_cond(f3, a, b);
      e.target = pc + ib;
    end
    rv_exu_pkg::OP_LOAD: begin
      ok = (f3 >= 3'd1) && (f3 <= 3'd5);
      e.reg_wr = ok;
      e.mem_rd = ok;
      e.result = a + ii;
      e.mem_op = mem_code(f3);
    end
    rv_exu_pkg::OP_STORE: begin
      ok = !f3[2];
      e.mem_wr = ok;
      e.result = a + is;  // address
      e.wdata = b;
      e.mem_op = mem_code(f3);
    end
    rv_exu_pkg::OP_IMM: begin
      ok = 1'b1;
      case (f3)
        3'b000: e.result = a + ii;
        3'b011: e.result = {63'b0, a < ii};
        3'b111: e.result = a & ii;
        3'b001: begin
          e.result = a << ii[5:0];
          ok = (f7[6:1] == 6'b0);
        end
        default: ok = 1'b0;
      endcase
      e.reg_wr = ok;
    end
    rv_exu_pkg::OP_IMM32: begin
      ok = (f3 == 3'b000);
      e.reg_wr = ok;
      e.result = sext_word(a + ii);
    end
    rv_exu_pkg::OP_REG: begin
      ok = 1'b1;
      if (f3 == 3'b000 && f7 == 7'h00) e.result = a + b;
      else if (f3 == 3'b000 && f7 == 7'h20) e.result = a - b;
      else if (f3 == 3'b110 && f7 == 7'h00) e.result = a | b;
      else ok = 1'b0;
      e.reg_wr = ok;
    end
    rv_exu_pkg::OP_REG32: begin
      ok = 1'b1;
      if (f3 == 3'b000 && f7 == 7'h00) e.result = sext_word(a + b);
      else if (f3 == 3'b000 && f7 == 7'h20) e.result = sext_word(a - b);
      else if (f3 == 3'b001 && f7 == 7'h00) e.result = sext_word(a << b[4:0]);
      else ok = 1'b0;
      e.reg_wr = ok;
    end
    rv_exu_pkg::OP_SYSTEM: begin
      ok = (inst == 32'h00100073);
      e.ebreak = ok;
    end
    default: ok = 1'b0;
  endcase
  e.illegal = !ok;
  return e;
endfunction

`endif

//--- bench/rv_exu_tb.sv
// rv64i execute front testbench
module rv_exu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_CYCLES     = 2000;
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN        = 6;
  localparam int CYCLE_LIMIT  = N_CYCLES + RESET_CYCLES + 20;

  `include "rv_exu_model.svh"

  logic        i_clk, i_rst_n, i_valid;
  logic [63:0] i_pc, i_rs1_val, i_rs2_val;
  logic [31:0] i_inst;
  logic        o_valid, o_reg_wr, o_mem_rd, o_mem_wr, o_br_taken, o_ebreak, o_illegal;
  logic [63:0] o_pc, o_result, o_mem_wdata, o_br_target;
  logic [4:0]  o_rd;
  logic [2:0]  o_mem_op;

  logic [15:0] lfsr = 16'd43477;
  int          tick_cnt = 0;
  exp_t        exp_q[$];
  int          due_q[$];

  rv_exu_pipe dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v[k] = lfsr_step();
    return v;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp, act);
    fail_run($sformatf("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act));
  endtask

  task automatic check_field(input string name, input logic [63:0] exp, act);
    assert (exp === act) else report_mismatch(name, exp, act);
  endtask

  task automatic check_outputs(input exp_t e);
    check_field("o_pc", e.pc, o_pc);
    check_field("o_rd", 64'(e.rd), 64'(o_rd));
    check_field("o_reg_wr", 64'(e.reg_wr), 64'(o_reg_wr));
    check_field("o_mem_rd", 64'(e.mem_rd), 64'(o_mem_rd));
    check_field("o_mem_wr", 64'(e.mem_wr), 64'(o_mem_wr));
    check_field("o_br_taken", 64'(e.taken), 64'(o_br_taken));
    check_field("o_ebreak", 64'(e.ebreak), 64'(o_ebreak));
    check_field("o_illegal", 64'(e.illegal), 64'(o_illegal));
    if (e.reg_wr || e.mem_rd || e.mem_wr) check_field("o_result", e.result, o_result);
    if (e.mem_rd || e.mem_wr) check_field("o_mem_op", 64'(e.mem_op), 64'(o_mem_op));
    if (e.mem_wr) check_field("o_mem_wdata", e.wdata, o_mem_wdata);
    if (e.taken) check_field("o_br_target", e.target, o_br_target);
  endtask

  task automatic build_stimulus(output logic v, output logic [31:0] inst,
                                output logic [63:0] pc, a, b);
    logic [6:0] opc_list [12];
    logic [2:0] cls;
    int         idx;
    opc_list = '{rv_exu_pkg::OP_LUI, rv_exu_pkg::OP_AUIPC, rv_exu_pkg::OP_JAL,
                 rv_exu_pkg::OP_JALR, rv_exu_pkg::OP_BRANCH, rv_exu_pkg::OP_LOAD,
                 rv_exu_pkg::OP_STORE, rv_exu_pkg::OP_IMM, rv_exu_pkg::OP_IMM32,
                 rv_exu_pkg::OP_REG, rv_exu_pkg::OP_REG32, rv_exu_pkg::OP_SYSTEM};
    cls = 3'(take_bits(3));
    idx = int'(take_bits(4)) % 12;
    inst = {25'(take_bits(25)), opc_list[idx]};
    case (cls)
      3'd2: inst = 32'(take_bits(32));  // mostly illegal
      3'd3: inst = 32'h00100073;
      3'd4: inst[6:0] = rv_exu_pkg::OP_BRANCH;
      3'd5,
      3'd6: inst[6:0] = lfsr_step() ? rv_exu_pkg::OP_REG32 : rv_exu_pkg::OP_IMM32;
      default: ;
    endcase
    // bias funct7 toward legal encodings
    if (lfsr_step()) inst[31:25] = lfsr_step() ? 7'h20 : 7'h00;
    pc = {62'(take_bits(62)), 2'b00};
    a = take_bits(64);
    b = take_bits(64);
    if (take_bits(2) == 64'd0) b = a;
    v = (take_bits(2) != 64'd0);  // about 3/4
  endtask

  always @(posedge i_clk) begin
    tick_cnt <= tick_cnt + 1;
    if (tick_cnt == CYCLE_LIMIT) fail_run("timeout: run did not finish in time");
  end

  initial begin
    logic        v, exp_v;
    logic [31:0] inst;
    logic [63:0] pc, a, b;
    exp_t        e;
    i_rst_n   = 1'b0;
    i_valid   = 1'b0;
    i_pc      = '0;
    i_inst    = '0;
    i_rs1_val = '0;
    i_rs2_val = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int cyc = 0; cyc < N_CYCLES + DRAIN; cyc++) begin
      @(posedge i_clk);
      exp_v = (due_q.size() > 0) && (due_q[0] == cyc);
      assert (o_valid === exp_v) else report_mismatch("o_valid", 64'(exp_v), 64'(o_valid));
      if (exp_v) begin
        e = exp_q.pop_front();
        void'(due_q.pop_front());
        check_outputs(e);
      end
      if (cyc < N_CYCLES) begin
        build_stimulus(v, inst, pc, a, b);
        i_valid   <= v;
        i_inst    <= inst;
        i_pc      <= pc;
        i_rs1_val <= a;
        i_rs2_val <= b;
        if (v) begin
          exp_q.push_back(model_exec(pc, inst, a, b));
          due_q.push_back(cyc + 4);  // drive edge plus three stages
        end
      end else begin
        i_valid <= 1'b0;
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- logic/rv_decode_stage.sv
// rv64i decode stage
module rv_decode_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [rv_exu_pkg::XLEN-1:0] i_pc,
  input  logic [rv_exu_pkg::ILEN-1:0] i_inst,
  input  logic [rv_exu_pkg::XLEN-1:0] i_rs1_val, i_rs2_val,
  output logic                        o_valid,
  output logic [rv_exu_pkg::XLEN-1:0] o_pc, o_rs1_val, o_rs2_val, o_imm,
  output logic [4:0]                  o_rd,
  output logic                        o_asrc,
  output logic [1:0]                  o_bsrc,
  output logic [3:0]                  o_alu_op,
  output logic [2:0]                  o_branch,
  output logic                        o_br_unsigned, o_word_cut,
  output logic                        o_reg_wr, o_mem_rd, o_mem_wr,
  output logic [2:0]                  o_mem_op
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rv_exu_pkg::XLEN-1:0] imm;
  logic [3:0] alu_op;
  logic [2:0] branch;
  logic [2:0] mem_op;
  logic [1:0] bsrc;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  wire [63:0] imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  wire [63:0] imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  wire [63:0] imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  wire [63:0] imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  wire [63:0] imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  wire op_imm   = (opcode == rv_exu_pkg::OP_IMM);
  wire op_reg   = (opcode == rv_exu_pkg::OP_REG);
  wire op_reg32 = (opcode == rv_exu_pkg::OP_REG32);

  wire inst_lui    = (opcode == rv_exu_pkg::OP_LUI);
  wire inst_auipc  = (opcode == rv_exu_pkg::OP_AUIPC);
  wire inst_jal    = (opcode == rv_exu_pkg::OP_JAL);
  wire inst_jalr   = (opcode == rv_exu_pkg::OP_JALR) & (funct3 == 3'b000);
  wire inst_branch = (opcode == rv_exu_pkg::OP_BRANCH) & (funct3[2:1] != 2'b01);
  // lh lw ld lbu lhu
  wire inst_load   = (opcode == rv_exu_pkg::OP_LOAD) & (funct3 != 3'b000) & (funct3 <= 3'b101);
  wire inst_store  = (opcode == rv_exu_pkg::OP_STORE) & !funct3[2];
  wire inst_addi   = op_imm & (funct3 == 3'b000);
  wire inst_sltiu  = op_imm & (funct3 == 3'b011);
  wire inst_andi   = op_imm & (funct3 == 3'b111);
  wire inst_slli   = op_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b0);
  wire inst_add    = op_reg & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  wire inst_sub    = op_reg & (funct3 == 3'b000) & (funct7 == 7'b0100000);
  wire inst_or     = op_reg & (funct3 == 3'b110) & (funct7 == 7'b0000000);
  wire inst_addiw  = (opcode == rv_exu_pkg::OP_IMM32) & (funct3 == 3'b000);
  wire inst_addw   = op_reg32 & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  wire inst_subw   = op_reg32 & (funct3 == 3'b000) & (funct7 == 7'b0100000);
  wire inst_sllw   = op_reg32 & (funct3 == 3'b001) & (funct7 == 7'b0000000);
  wire inst_ebreak = (opcode == rv_exu_pkg::OP_SYSTEM) & (i_inst[31:7] == 25'h0002000);

  wire type_r = |{inst_add, inst_sub, inst_or, inst_addw, inst_subw, inst_sllw};
  wire type_i = |{inst_jalr, inst_load, inst_addi, inst_sltiu, inst_andi, inst_slli,
                  inst_addiw, inst_ebreak};
  wire type_u = inst_lui | inst_auipc;

  always_comb begin
    case (1'b1)
      type_i:      imm = imm_i;
      type_u:      imm = imm_u;
      inst_store:  imm = imm_s;
      inst_branch: imm = imm_b;
      inst_jal:    imm = imm_j;
      default:     imm = '0;  // r type has none
    endcase
  end

  always_comb begin
    if (inst_lui) alu_op = rv_exu_pkg::ALU_COPYIMM;
    else if (|{inst_auipc, inst_jal, inst_jalr, inst_addi, inst_add, inst_load,
               inst_store, inst_addiw, inst_addw}) alu_op = rv_exu_pkg::ALU_ADD;
    else if (inst_branch | inst_sub | inst_subw) alu_op = rv_exu_pkg::ALU_SUB;
    else if (inst_sltiu) alu_op = rv_exu_pkg::ALU_SLTU;
    else if (inst_andi) alu_op = rv_exu_pkg::ALU_AND;
    else if (inst_or) alu_op = rv_exu_pkg::ALU_OR;
    else if (inst_slli | inst_sllw) alu_op = rv_exu_pkg::ALU_SLL;
    else if (inst_ebreak) alu_op = rv_exu_pkg::ALU_EBREAK;
    else alu_op = rv_exu_pkg::ALU_INVALID;
  end

  always_comb begin
    branch = rv_exu_pkg::BR_NONE;
    if (inst_jal) branch = rv_exu_pkg::BR_JAL;
    else if (inst_jalr) branch = rv_exu_pkg::BR_JALR;
    else if (inst_branch) begin
      case (funct3)
        3'b000:  branch = rv_exu_pkg::BR_EQ;
        3'b001:  branch = rv_exu_pkg::BR_NE;
        3'b100:  branch = rv_exu_pkg::BR_LT;
        3'b101:  branch = rv_exu_pkg::BR_GE;
        3'b110:  branch = rv_exu_pkg::BR_LTU;
        default: branch = rv_exu_pkg::BR_GEU;
      endcase
    end
  end

  always_comb begin
    mem_op = rv_exu_pkg::MEM_NONE;
    if (inst_load | inst_store) begin
      case (funct3)
        3'b000:  mem_op = rv_exu_pkg::MEM_SB;
        3'b001:  mem_op = rv_exu_pkg::MEM_SH;
        3'b010:  mem_op = rv_exu_pkg::MEM_SW;
        3'b011:  mem_op = rv_exu_pkg::MEM_SD;
        3'b100:  mem_op = rv_exu_pkg::MEM_UB;
        3'b101:  mem_op = rv_exu_pkg::MEM_UH;
        default: mem_op = rv_exu_pkg::MEM_UW;  // lwu, never decoded
      endcase
    end
  end

  always_comb begin
    if (inst_jal | inst_jalr) bsrc = rv_exu_pkg::BSRC_FOUR;
    else if (type_i | type_u | inst_store) bsrc = rv_exu_pkg::BSRC_IMM;
    else bsrc = rv_exu_pkg::BSRC_RS2;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc          <= i_pc;
    o_rs1_val     <= i_rs1_val;
    o_rs2_val     <= i_rs2_val;
    o_imm         <= imm;
    o_rd          <= i_inst[11:7];
    o_asrc        <= (inst_jal | inst_jalr | inst_auipc) ? rv_exu_pkg::ASRC_PC
                                                         : rv_exu_pkg::ASRC_RS1;
    o_bsrc        <= bsrc;
    o_alu_op      <= alu_op;
    o_branch      <= branch;
    o_br_unsigned <= funct3[1];
    o_word_cut    <= |{inst_addiw, inst_addw, inst_subw, inst_sllw};
    o_reg_wr      <= type_r | type_u | inst_jal | (type_i & !inst_ebreak);
    o_mem_rd      <= inst_load;
    o_mem_wr      <= inst_store;
    o_mem_op      <= mem_op;
  end

endmodule

//--- logic/rv_exec_stage.sv
// rv64i execute stage
module rv_exec_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [rv_exu_pkg::XLEN-1:0] i_pc, i_rs1_val, i_rs2_val, i_imm,
  input  logic [4:0]                  i_rd,
  input  logic                        i_asrc,
  input  logic [1:0]                  i_bsrc,
  input  logic [3:0]                  i_alu_op,
  input  logic [2:0]                  i_branch,
  input  logic                        i_br_unsigned, i_word_cut,
  input  logic                        i_reg_wr, i_mem_rd, i_mem_wr,
  input  logic [2:0]                  i_mem_op,
  output logic                        o_valid,
  output logic [rv_exu_pkg::XLEN-1:0] o_pc, o_alu_res, o_rs2_val,
  output logic [4:0]                  o_rd,
  output logic                        o_word_cut, o_reg_wr, o_mem_rd, o_mem_wr,
  output logic [2:0]                  o_mem_op,
  output logic                        o_br_taken,
  output logic [rv_exu_pkg::XLEN-1:0] o_br_target,
  output logic                        o_ebreak, o_illegal
);

  logic [rv_exu_pkg::XLEN-1:0] op_a, op_b, alu_res, jalr_sum;
  logic [5:0] shamt;
  logic       lt;
  logic       taken;

  assign op_a  = (i_asrc == rv_exu_pkg::ASRC_PC) ? i_pc : i_rs1_val;
  assign shamt = i_word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];  // 5 bit shift for w ops
  assign lt    = i_br_unsigned ? (i_rs1_val < i_rs2_val)
                               : ($signed(i_rs1_val) < $signed(i_rs2_val));
  assign jalr_sum = i_rs1_val + i_imm;

  always_comb begin
    case (i_bsrc)
      rv_exu_pkg::BSRC_RS2:  op_b = i_rs2_val;
      rv_exu_pkg::BSRC_IMM:  op_b = i_imm;
      rv_exu_pkg::BSRC_FOUR: op_b = 64'd4;
      default:               op_b = '0;
    endcase
  end

  always_comb begin
    case (i_alu_op)
      rv_exu_pkg::ALU_ADD:     alu_res = op_a + op_b;
      rv_exu_pkg::ALU_SUB:     alu_res = op_a - op_b;
      rv_exu_pkg::ALU_SLTU:    alu_res = {63'b0, op_a < op_b};
      rv_exu_pkg::ALU_AND:     alu_res = op_a & op_b;
      rv_exu_pkg::ALU_OR:      alu_res = op_a | op_b;
      rv_exu_pkg::ALU_SLL:     alu_res = op_a << shamt;
      rv_exu_pkg::ALU_COPYIMM: alu_res = op_b;
      default:                 alu_res = '0;
    endcase
  end

  always_comb begin
    case (i_branch)
      rv_exu_pkg::BR_JAL,
      rv_exu_pkg::BR_JALR: taken = 1'b1;
      rv_exu_pkg::BR_EQ:   taken = (i_rs1_val == i_rs2_val);
      rv_exu_pkg::BR_NE:   taken = (i_rs1_val != i_rs2_val);
      rv_exu_pkg::BR_LT:   taken = lt;
      rv_exu_pkg::BR_GE:   taken = !lt;
      default:             taken = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc        <= i_pc;
    o_alu_res   <= alu_res;
    o_rs2_val   <= i_rs2_val;
    o_rd        <= i_rd;
    o_word_cut  <= i_word_cut;
    o_reg_wr    <= i_reg_wr;
    o_mem_rd    <= i_mem_rd;
    o_mem_wr    <= i_mem_wr;
    o_mem_op    <= i_mem_op;
    o_br_taken  <= taken;
    o_br_target <= (i_branch == rv_exu_pkg::BR_JALR) ? {jalr_sum[63:1], 1'b0}
                                                     : i_pc + i_imm;
    o_ebreak    <= (i_alu_op == rv_exu_pkg::ALU_EBREAK);
    o_illegal   <= (i_alu_op == rv_exu_pkg::ALU_INVALID);
  end

endmodule

//--- logic/rv_exu_pipe.sv
// rv64i execute front top
module rv_exu_pipe (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [rv_exu_pkg::XLEN-1:0] i_pc,
  input  logic [rv_exu_pkg::ILEN-1:0] i_inst,
  input  logic [rv_exu_pkg::XLEN-1:0] i_rs1_val, i_rs2_val,
  output logic                        o_valid,
  output logic [rv_exu_pkg::XLEN-1:0] o_pc,
  output logic [4:0]                  o_rd,
  output logic                        o_reg_wr,
  output logic [rv_exu_pkg::XLEN-1:0] o_result,
  output logic                        o_mem_rd, o_mem_wr,
  output logic [2:0]                  o_mem_op,
  output logic [rv_exu_pkg::XLEN-1:0] o_mem_wdata,
  output logic                        o_br_taken,
  output logic [rv_exu_pkg::XLEN-1:0] o_br_target,
  output logic                        o_ebreak, o_illegal
);

  // decode to execute
  logic                        d_valid;
  logic [rv_exu_pkg::XLEN-1:0] d_pc, d_rs1_val, d_rs2_val, d_imm;
  logic [4:0]                  d_rd;
  logic                        d_asrc;
  logic [1:0]                  d_bsrc;
  logic [3:0]                  d_alu_op;
  logic [2:0]                  d_branch, d_mem_op;
  logic                        d_br_unsigned, d_word_cut, d_reg_wr, d_mem_rd, d_mem_wr;

  // execute to result
  logic                        e_valid;
  logic [rv_exu_pkg::XLEN-1:0] e_pc, e_alu_res, e_rs2_val, e_br_target;
  logic [4:0]                  e_rd;
  logic [2:0]                  e_mem_op;
  logic                        e_word_cut, e_reg_wr, e_mem_rd, e_mem_wr;
  logic                        e_br_taken, e_ebreak, e_illegal;

  rv_decode_stage decode_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .i_pc          (i_pc),
    .i_inst        (i_inst),
    .i_rs1_val     (i_rs1_val),
    .i_rs2_val     (i_rs2_val),
    .o_valid       (d_valid),
    .o_pc          (d_pc),
    .o_rs1_val     (d_rs1_val),
    .o_rs2_val     (d_rs2_val),
    .o_imm         (d_imm),
    .o_rd          (d_rd),
    .o_asrc        (d_asrc),
    .o_bsrc        (d_bsrc),
    .o_alu_op      (d_alu_op),
    .o_branch      (d_branch),
    .o_br_unsigned (d_br_unsigned),
    .o_word_cut    (d_word_cut),
    .o_reg_wr      (d_reg_wr),
    .o_mem_rd      (d_mem_rd),
    .o_mem_wr      (d_mem_wr),
    .o_mem_op      (d_mem_op)
  );

  rv_exec_stage exec_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (d_valid),
    .i_pc          (d_pc),
    .i_rs1_val     (d_rs1_val),
    .i_rs2_val     (d_rs2_val),
    .i_imm         (d_imm),
    .i_rd          (d_rd),
    .i_asrc        (d_asrc),
    .i_bsrc        (d_bsrc),
    .i_alu_op      (d_alu_op),
    .i_branch      (d_branch),
    .i_br_unsigned (d_br_unsigned),
    .i_word_cut    (d_word_cut),
    .i_reg_wr      (d_reg_wr),
    .i_mem_rd      (d_mem_rd),
    .i_mem_wr      (d_mem_wr),
    .i_mem_op      (d_mem_op),
    .o_valid       (e_valid),
    .o_pc          (e_pc),
    .o_alu_res     (e_alu_res),
    .o_rs2_val     (e_rs2_val),
    .o_rd          (e_rd),
    .o_word_cut    (e_word_cut),
    .o_reg_wr      (e_reg_wr),
    .o_mem_rd      (e_mem_rd),
    .o_mem_wr      (e_mem_wr),
    .o_mem_op      (e_mem_op),
    .o_br_taken    (e_br_taken),
    .o_br_target   (e_br_target),
    .o_ebreak      (e_ebreak),
    .o_illegal     (e_illegal)
  );

  rv_result_stage result_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (e_valid),
    .i_pc        (e_pc),
    .i_alu_res   (e_alu_res),
    .i_rs2_val   (e_rs2_val),
    .i_rd        (e_rd),
    .i_word_cut  (e_word_cut),
    .i_reg_wr    (e_reg_wr),
    .i_mem_rd    (e_mem_rd),
    .i_mem_wr    (e_mem_wr),
    .i_mem_op    (e_mem_op),
    .i_br_taken  (e_br_taken),
    .i_br_target (e_br_target),
    .i_ebreak    (e_ebreak),
    .i_illegal   (e_illegal),
    .o_valid     (o_valid),
    .o_pc        (o_pc),
    .o_rd        (o_rd),
    .o_reg_wr    (o_reg_wr),
    .o_result    (o_result),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_op    (o_mem_op),
    .o_mem_wdata (o_mem_wdata),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target),
    .o_ebreak    (o_ebreak),
    .o_illegal   (o_illegal)
  );

endmodule

//--- logic/rv_exu_pkg.sv
// rv64i execute front definitions
package rv_exu_pkg;

  localparam int XLEN = 64;  // data and address width
  localparam int ILEN = 32;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [3:0] ALU_ADD     = 4'b0000;
  localparam logic [3:0] ALU_SLL     = 4'b0001;
  localparam logic [3:0] ALU_COPYIMM = 4'b0011;  // pass operand b
  localparam logic [3:0] ALU_OR      = 4'b0110;
  localparam logic [3:0] ALU_AND     = 4'b0111;
  localparam logic [3:0] ALU_SUB     = 4'b1000;
  localparam logic [3:0] ALU_SLTU    = 4'b1010;
  localparam logic [3:0] ALU_EBREAK  = 4'b1110;
  localparam logic [3:0] ALU_INVALID = 4'b1111;

  // lt/ltu and ge/geu share codes, signedness rides separately
  localparam logic [2:0] BR_NONE = 3'b000;
  localparam logic [2:0] BR_JAL  = 3'b001;
  localparam logic [2:0] BR_JALR = 3'b010;
  localparam logic [2:0] BR_EQ   = 3'b100;
  localparam logic [2:0] BR_NE   = 3'b101;
  localparam logic [2:0] BR_LT   = 3'b110;
  localparam logic [2:0] BR_GE   = 3'b111;
  localparam logic [2:0] BR_LTU  = 3'b110;
  localparam logic [2:0] BR_GEU  = 3'b111;

  localparam logic [2:0] MEM_SB   = 3'b000;
  localparam logic [2:0] MEM_UB   = 3'b001;
  localparam logic [2:0] MEM_SH   = 3'b010;
  localparam logic [2:0] MEM_UH   = 3'b011;
  localparam logic [2:0] MEM_SW   = 3'b100;
  localparam logic [2:0] MEM_UW   = 3'b101;
  localparam logic [2:0] MEM_SD   = 3'b110;
  localparam logic [2:0] MEM_NONE = 3'b111;

  localparam logic ASRC_RS1 = 1'b0;
  localparam logic ASRC_PC  = 1'b1;

  localparam logic [1:0] BSRC_RS2  = 2'b00;
  localparam logic [1:0] BSRC_IMM  = 2'b01;
  localparam logic [1:0] BSRC_FOUR = 2'b10;  // return address pc + 4

endpackage

//--- logic/rv_result_stage.sv
// rv64i result stage
module rv_result_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [rv_exu_pkg::XLEN-1:0] i_pc, i_alu_res, i_rs2_val,
  input  logic [4:0]                  i_rd,
  input  logic                        i_word_cut, i_reg_wr, i_mem_rd, i_mem_wr,
  input  logic [2:0]                  i_mem_op,
  input  logic                        i_br_taken,
  input  logic [rv_exu_pkg::XLEN-1:0] i_br_target,
  input  logic                        i_ebreak, i_illegal,
  output logic                        o_valid,
  output logic [rv_exu_pkg::XLEN-1:0] o_pc,
  output logic [4:0]                  o_rd,
  output logic                        o_reg_wr,
  output logic [rv_exu_pkg::XLEN-1:0] o_result,
  output logic                        o_mem_rd, o_mem_wr,
  output logic [2:0]                  o_mem_op,
  output logic [rv_exu_pkg::XLEN-1:0] o_mem_wdata,
  output logic                        o_br_taken,
  output logic [rv_exu_pkg::XLEN-1:0] o_br_target,
  output logic                        o_ebreak, o_illegal
);

  logic [rv_exu_pkg::XLEN-1:0] result;

  // w ops keep the low word, sign extended
  assign result = i_word_cut ? {{32{i_alu_res[31]}}, i_alu_res[31:0]} : i_alu_res;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      o_reg_wr   <= 1'b0;
      o_mem_rd   <= 1'b0;
      o_mem_wr   <= 1'b0;
      o_br_taken <= 1'b0;
      o_ebreak   <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_valid    <= i_valid;
      o_reg_wr   <= i_valid & i_reg_wr;
      o_mem_rd   <= i_valid & i_mem_rd;
      o_mem_wr   <= i_valid & i_mem_wr;
      o_br_taken <= i_valid & i_br_taken;
      o_ebreak   <= i_valid & i_ebreak;
      o_illegal  <= i_valid & i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc        <= i_pc;
    o_rd        <= i_rd;
    o_result    <= result;  // also the load/store address
    o_mem_op    <= i_mem_op;
    o_mem_wdata <= i_rs2_val;
    o_br_target <= i_br_target;
  end

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rv_exu_tb -f src.f -o rv_exu_sim
./obj_dir/rv_exu_sim

//--- src.f
+incdir+bench
logic/rv_exu_pkg.sv
logic/rv_decode_stage.sv
logic/rv_exec_stage.sv
logic/rv_result_stage.sv
logic/rv_exu_pipe.sv
bench/rv_exu_assert.sv
bench/rv_exu_tb.sv
